//--- Makefile
TOP := tb_lsu

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

# pass only when the pass message appears on a line of its own
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- files.f
+incdir+logic
logic/lsu_pkg.sv
logic/amo_alu.sv
logic/amo_engine.sv
logic/dcache_port.sv
logic/ls_control.sv
logic/lsu_top.sv
tests/tb_lsu_mem.sv
tests/tb_lsu.sv

//--- logic/amo_alu.sv
`timescale 1ns/10ps

module amo_alu import lsu_pkg::*; #(
    parameter int XLEN = $bits(mem_word_u)
) (
    input  logic [XLEN-1:0] old_i,
    input  logic [XLEN-1:0] operand_i,
    input  amo_op_e         kind_i,
    output logic [XLEN-1:0] new_o
);

    logic lt_signed;
    logic lt_unsigned;

    // both compare flavours for the min and max kinds
    assign lt_signed   = $signed(old_i) < $signed(operand_i);
    assign lt_unsigned = old_i < operand_i;

    always_comb begin
        case (kind_i)
            AMOOP_SWAP: new_o = operand_i;
            AMOOP_ADD:  new_o = old_i + operand_i;
            AMOOP_XOR:  new_o = old_i ^ operand_i;
            AMOOP_AND:  new_o = old_i & operand_i;
            AMOOP_OR:   new_o = old_i | operand_i;
            // keep the smaller signed value
            AMOOP_MIN:  new_o = lt_signed ? old_i : operand_i;
            AMOOP_MAX:  new_o = lt_signed ? operand_i : old_i;
            // unsigned variants
            AMOOP_MINU: new_o = lt_unsigned ? old_i : operand_i;
            AMOOP_MAXU: new_o = lt_unsigned ? operand_i : old_i;
            // unknown kinds act as swap
            default:    new_o = operand_i;
        endcase
    end

endmodule

//--- logic/amo_engine.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module amo_engine import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_op_e              mem_op_i,
    input  amo_op_e              amo_op_i,
    input  logic [`LSU_XLEN-1:0] addr_i,
    input  logic [`LSU_XLEN-1:0] wdata_i,
    input  logic                 plain_store_done_i,
    input  logic                 bus_ready_i,
    input  logic [`LSU_XLEN-1:0] bus_rdata_i,
    output logic                 req_o,
    output logic                 write_o,
    output logic [`LSU_XLEN-1:0] wdata_o,
    output logic                 done_o,
    output logic [`LSU_XLEN-1:0] result_o,
    output logic                 misalign_o
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_LOAD   = 3'd1;
    localparam logic [2:0] S_CALC   = 3'd2;
    localparam logic [2:0] S_STORE  = 3'd3;
    localparam logic [2:0] S_FINISH = 3'd4;

    logic [2:0]           state_q;
    logic [2:0]           state_d;
    logic                 finish_d;
    logic                 done_q;
    logic                 misalign_q;
    logic                 resv_valid_q;
    logic [`LSU_XLEN-1:0] resv_addr_q;
    logic [`LSU_XLEN-1:0] old_q;
    logic [`LSU_XLEN-1:0] wdata_q;
    logic [`LSU_XLEN-1:0] result_q;
    logic [`LSU_XLEN-1:0] alu_new;
    logic                 is_atomic;
    logic                 misaligned;
    logic                 start;
    logic                 sc_ok;

    // only the atomic codes belong to this client
    assign is_atomic  = mem_op_i inside {MEMOP_LR_W, MEMOP_SC_W, MEMOP_AMO};
    assign misaligned = addr_i[1:0] != 2'b00;
    assign start      = (state_q == S_IDLE) && is_atomic;
    // sc wins only on a live reservation to the same word
    assign sc_ok      = resv_valid_q && (resv_addr_q == addr_i);

    amo_alu i_amo_alu (
        .old_i     (old_q),
        .operand_i (wdata_i),
        .kind_i    (amo_op_i),
        .new_o     (alu_new)
    );

    always_comb begin
        state_d  = state_q;
        finish_d = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (is_atomic) begin
                    // misaligned or failed sc skip the bus entirely
                    if (misaligned || (mem_op_i == MEMOP_SC_W && !sc_ok)) begin
                        state_d  = S_FINISH;
                        finish_d = 1'b1;
                    end else if (mem_op_i == MEMOP_SC_W) begin
                        state_d = S_STORE;
                    end else begin
                        state_d = S_LOAD;
                    end
                end
            end
            S_LOAD: begin
                if (bus_ready_i) begin
                    // lr ends here, amo goes on to the calculation
                    state_d  = (mem_op_i == MEMOP_LR_W) ? S_FINISH : S_CALC;
                    finish_d = mem_op_i == MEMOP_LR_W;
                end
            end
            S_CALC: state_d = S_STORE;
            S_STORE: begin
                if (bus_ready_i) begin
                    state_d  = S_FINISH;
                    finish_d = 1'b1;
                end
            end
            // wait for the op to drop so a held op never restarts
            S_FINISH: begin
                if (mem_op_i == MEMOP_NONE) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= S_IDLE;
            done_q       <= 1'b0;
            misalign_q   <= 1'b0;
            resv_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // one pulse on entry to finish
            done_q  <= finish_d;
            if (start) begin
                misalign_q <= misaligned;
            end
            // reservation set by lr, cleared by sc or a plain store
            if (start && !misaligned && mem_op_i == MEMOP_LR_W) begin
                resv_valid_q <= 1'b1;
            end else if ((start && mem_op_i == MEMOP_SC_W) || plain_store_done_i) begin
                resv_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && mem_op_i == MEMOP_LR_W) begin
            resv_addr_q <= addr_i;
        end
        if (start && mem_op_i == MEMOP_SC_W) begin
            wdata_q <= wdata_i;
        end else if (state_q == S_CALC) begin
            wdata_q <= alu_new;
        end
        if (state_q == S_LOAD && bus_ready_i) begin
            old_q <= bus_rdata_i;
        end
        // sc reports 0 on success and 1 on failure
        if (start && misaligned) begin
            result_q <= '0;
        end else if (start && mem_op_i == MEMOP_SC_W) begin
            result_q <= {{(`LSU_XLEN-1){1'b0}}, !sc_ok};
        end else if (state_q == S_LOAD && bus_ready_i) begin
            result_q <= bus_rdata_i;
        end
    end

    assign req_o      = (state_q == S_LOAD) || (state_q == S_STORE);
    assign write_o    = state_q == S_STORE;
    assign wdata_o    = wdata_q;
    assign done_o     = done_q;
    assign result_o   = result_q;
    assign misalign_o = misalign_q;

    // a misaligned atomic must never reach the cache
    a_no_misaligned_req: assert property (@(posedge clk) disable iff (rst)
        $rose(req_o) |-> addr_i[1:0] == 2'b00);

endmodule

//--- logic/dcache_port.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module dcache_port import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  plain_req_i,
    input  logic                  plain_write_i,
    input  logic [`LSU_LANES-1:0] plain_size_i,
    input  logic [`LSU_XLEN-1:0]  plain_addr_i,
    input  logic [`LSU_XLEN-1:0]  plain_wdata_i,
    input  logic                  amo_req_i,
    input  logic                  amo_write_i,
    input  logic [`LSU_XLEN-1:0]  amo_addr_i,
    input  logic [`LSU_XLEN-1:0]  amo_wdata_i,
    output logic                  bus_ready_o,
    output logic [`LSU_XLEN-1:0]  bus_rdata_o,
    output logic [`LSU_XLEN-1:0]  mem_addr_o,
    output logic                  mem_addr_valid_o,
    output logic                  mem_write_o,
    output logic [`LSU_LANES-1:0] mem_mask_o,
    output logic [`LSU_XLEN-1:0]  mem_wdata_o,
    input  logic                  mem_data_ready_i,
    input  logic [`LSU_XLEN-1:0]  mem_rdata_i
);

    mem_word_u plain_lanes;

    // copy the low byte or halfword onto every lane
    always_comb begin
        case (plain_size_i)
            4'b0001: plain_lanes.b = {`LSU_LANES{plain_wdata_i[7:0]}};
            4'b0011: plain_lanes.h = {(`LSU_LANES/2){plain_wdata_i[15:0]}};
            default: plain_lanes   = plain_wdata_i;
        endcase
    end

    // atomics are whole words, plain accesses shift their size mask
    assign mem_addr_valid_o = plain_req_i || amo_req_i;
    assign mem_addr_o       = amo_req_i ? amo_addr_i : plain_addr_i;
    assign mem_write_o      = amo_req_i ? amo_write_i : plain_write_i;
    assign mem_mask_o       = amo_req_i ? {`LSU_LANES{1'b1}}
                                        : plain_size_i << plain_addr_i[1:0];
    assign mem_wdata_o      = amo_req_i ? amo_wdata_i : plain_lanes;

    // ready and read data go back to both clients
    assign bus_ready_o = mem_data_ready_i;
    assign bus_rdata_o = mem_rdata_i;

    // only one client may own the port at a time
    a_one_client: assert property (@(posedge clk) disable iff (rst)
        !(plain_req_i && amo_req_i));

    // the cache answers only an open request
    a_ready_needs_req: assert property (@(posedge clk) disable iff (rst)
        mem_data_ready_i |-> mem_addr_valid_o);

endmodule

//--- logic/ls_control.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module ls_control import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_op_e               mem_op_i,
    input  logic [`LSU_XLEN-1:0]  addr_i,
    input  logic [`LSU_XLEN-1:0]  wdata_i,
    input  logic                  bus_ready_i,
    input  logic [`LSU_XLEN-1:0]  bus_rdata_i,
    output logic                  plain_req_o,
    output logic                  plain_write_o,
    output logic [`LSU_LANES-1:0] plain_size_o,
    output logic                  plain_store_done_o,
    input  logic                  done_amo_i,
    input  logic [`LSU_XLEN-1:0]  result_amo_i,
    input  logic                  misalign_i,
    output logic                  done_o,
    output logic [`LSU_XLEN-1:0]  result_o,
    output logic                  stall_o,
    output logic                  misalign_o
);

    logic                 is_load;
    logic                 is_store;
    logic                 completed_q;
    logic                 plain_done;
    logic                 done_q;
    logic                 misalign_q;
    logic [`LSU_XLEN-1:0] result_q;
    logic [`LSU_XLEN-1:0] load_val;
    logic [7:0]           rd_byte;
    logic [15:0]          rd_half;
    mem_word_u            rd_word;

    assign is_load  = mem_op_i inside {MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU, MEMOP_LW};
    assign is_store = mem_op_i inside {MEMOP_SB, MEMOP_SH, MEMOP_SW};

    // request drops once served, even if the op is still held
    assign plain_req_o        = (is_load || is_store) && !completed_q;
    assign plain_write_o      = is_store;
    assign plain_size_o       = mem_op_i inside {MEMOP_LB, MEMOP_LBU, MEMOP_SB} ? 4'b0001 :
                                mem_op_i inside {MEMOP_LH, MEMOP_LHU, MEMOP_SH} ? 4'b0011 :
                                                                                   4'b1111;
    assign plain_done         = plain_req_o && bus_ready_i;
    assign plain_store_done_o = plain_done && is_store;

    // pick the addressed lane and extend it
    always_comb begin
        rd_word = bus_rdata_i;
        rd_byte = rd_word.b[addr_i[1:0]];
        rd_half = rd_word.h[addr_i[1]];
        case (mem_op_i)
            MEMOP_LB:  load_val = {{24{rd_byte[7]}}, rd_byte};
            MEMOP_LBU: load_val = {24'b0, rd_byte};
            MEMOP_LH:  load_val = {{16{rd_half[15]}}, rd_half};
            MEMOP_LHU: load_val = {16'b0, rd_half};
            MEMOP_LW:  load_val = rd_word;
            // stores report zero
            default:   load_val = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            completed_q <= 1'b0;
            done_q      <= 1'b0;
            misalign_q  <= 1'b0;
        end else begin
            // held until the op returns to none
            if (mem_op_i == MEMOP_NONE) begin
                completed_q <= 1'b0;
            end else if (plain_done || done_amo_i) begin
                completed_q <= 1'b1;
            end
            done_q <= plain_done || done_amo_i;
            if (plain_done || done_amo_i) begin
                misalign_q <= done_amo_i && misalign_i;
            end
        end
    end

    // result held until the next completion
    always_ff @(posedge clk) begin
        if (done_amo_i) begin
            result_q <= result_amo_i;
        end else if (plain_done) begin
            result_q <= load_val;
        end
    end

    assign done_o     = done_q;
    assign result_o   = result_q;
    assign misalign_o = misalign_q;
    // active op not yet answered
    assign stall_o    = (mem_op_i != MEMOP_NONE) && !completed_q;

    // halfword and word accesses must be naturally aligned
    a_plain_aligned: assert property (@(posedge clk) disable iff (rst)
        plain_req_o |-> ((plain_size_o != 4'b0011 || !addr_i[0])
                      && (plain_size_o != 4'b1111 || addr_i[1:0] == 2'b00)));

    // store data stays put while the cache holds off
    a_wdata_stable: assert property (@(posedge clk) disable iff (rst)
        plain_req_o && plain_write_o && !bus_ready_i |=> $stable(wdata_i));

endmodule

//--- logic/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data word and address width
`define LSU_XLEN 32

// byte lanes per word and the mask width
`define LSU_LANES 4

// memory operation code width
`define LSU_OP_W 4

// amo kind code width
`define LSU_AMO_W 4

`endif

//--- logic/lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

    // memory operation from the pipeline held as a level
    typedef enum logic [`LSU_OP_W-1:0] {
        MEMOP_NONE = 4'd0,
        MEMOP_LB   = 4'd1,
        MEMOP_LBU  = 4'd2,
        MEMOP_LH   = 4'd3,
        MEMOP_LHU  = 4'd4,
        MEMOP_LW   = 4'd5,
        MEMOP_SB   = 4'd6,
        MEMOP_SH   = 4'd7,
        MEMOP_SW   = 4'd8,
        MEMOP_LR_W = 4'd9,
        MEMOP_SC_W = 4'd10,
        MEMOP_AMO  = 4'd11
    } mem_op_e;

    // read-modify-write kind used only with MEMOP_AMO
    typedef enum logic [`LSU_AMO_W-1:0] {
        AMOOP_SWAP = 4'd0,
        AMOOP_ADD  = 4'd1,
        AMOOP_XOR  = 4'd2,
        AMOOP_AND  = 4'd3,
        AMOOP_OR   = 4'd4,
        AMOOP_MIN  = 4'd5,
        AMOOP_MAX  = 4'd6,
        AMOOP_MINU = 4'd7,
        AMOOP_MAXU = 4'd8
    } amo_op_e;

    // one data word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [`LSU_LANES-1:0][7:0]     b;
        logic [`LSU_LANES/2-1:0][15:0]  h;
    } mem_word_u;

endpackage

//--- logic/lsu_top.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_top import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_op_e               mem_op_i,
    input  amo_op_e               amo_op_i,
    input  logic [`LSU_XLEN-1:0]  addr_i,
    input  logic [`LSU_XLEN-1:0]  wdata_i,
    output logic                  done_o,
    output logic [`LSU_XLEN-1:0]  result_o,
    output logic                  stall_o,
    output logic                  misalign_o,
    output logic [`LSU_XLEN-1:0]  mem_addr_o,
    output logic                  mem_addr_valid_o,
    output logic                  mem_write_o,
    output logic [`LSU_LANES-1:0] mem_mask_o,
    output logic [`LSU_XLEN-1:0]  mem_wdata_o,
    input  logic                  mem_data_ready_i,
    input  logic [`LSU_XLEN-1:0]  mem_rdata_i
);

    // plain client
    logic                  plain_req;
    logic                  plain_write;
    logic [`LSU_LANES-1:0] plain_size;
    logic                  plain_store_done;
    // atomic client
    logic                  amo_req;
    logic                  amo_write;
    logic [`LSU_XLEN-1:0]  amo_wdata;
    logic                  done_amo;
    logic [`LSU_XLEN-1:0]  result_amo;
    logic                  misalign;
    // shared return path
    logic                  bus_ready;
    logic [`LSU_XLEN-1:0]  bus_rdata;

    ls_control i_ls_control (
        .clk                (clk),
        .rst                (rst),
        .mem_op_i           (mem_op_i),
        .addr_i             (addr_i),
        .wdata_i            (wdata_i),
        .bus_ready_i        (bus_ready),
        .bus_rdata_i        (bus_rdata),
        .plain_req_o        (plain_req),
        .plain_write_o      (plain_write),
        .plain_size_o       (plain_size),
        .plain_store_done_o (plain_store_done),
        .done_amo_i         (done_amo),
        .result_amo_i       (result_amo),
        .misalign_i         (misalign),
        .done_o             (done_o),
        .result_o           (result_o),
        .stall_o            (stall_o),
        .misalign_o         (misalign_o)
    );

    amo_engine i_amo_engine (
        .clk                (clk),
        .rst                (rst),
        .mem_op_i           (mem_op_i),
        .amo_op_i           (amo_op_i),
        .addr_i             (addr_i),
        .wdata_i            (wdata_i),
        .plain_store_done_i (plain_store_done),
        .bus_ready_i        (bus_ready),
        .bus_rdata_i        (bus_rdata),
        .req_o              (amo_req),
        .write_o            (amo_write),
        .wdata_o            (amo_wdata),
        .done_o             (done_amo),
        .result_o           (result_amo),
        .misalign_o         (misalign)
    );

    // both clients address the word given by the pipeline
    dcache_port i_dcache_port (
        .clk              (clk),
        .rst              (rst),
        .plain_req_i      (plain_req),
        .plain_write_i    (plain_write),
        .plain_size_i     (plain_size),
        .plain_addr_i     (addr_i),
        .plain_wdata_i    (wdata_i),
        .amo_req_i        (amo_req),
        .amo_write_i      (amo_write),
        .amo_addr_i       (addr_i),
        .amo_wdata_i      (amo_wdata),
        .bus_ready_o      (bus_ready),
        .bus_rdata_o      (bus_rdata),
        .mem_addr_o       (mem_addr_o),
        .mem_addr_valid_o (mem_addr_valid_o),
        .mem_write_o      (mem_write_o),
        .mem_mask_o       (mem_mask_o),
        .mem_wdata_o      (mem_wdata_o),
        .mem_data_ready_i (mem_data_ready_i),
        .mem_rdata_i      (mem_rdata_i)
    );

endmodule

//--- tests/tb_lsu.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module tb_lsu import lsu_pkg::*; ();

    logic                  clk;
    logic                  rst;
    mem_op_e               mem_op;
    amo_op_e               amo_op;
    logic [`LSU_XLEN-1:0]  addr;
    logic [`LSU_XLEN-1:0]  wdata;
    logic                  done;
    logic [`LSU_XLEN-1:0]  result;
    logic                  stall;
    logic                  misalign;
    logic [`LSU_XLEN-1:0]  mem_addr;
    logic                  mem_addr_valid;
    logic                  mem_write;
    logic [`LSU_LANES-1:0] mem_mask;
    logic [`LSU_XLEN-1:0]  mem_wdata;
    logic                  mem_data_ready;
    logic [`LSU_XLEN-1:0]  mem_rdata;
    // reference model
    logic [`LSU_XLEN-1:0]  image [64];
    logic                  resv_valid;
    logic [`LSU_XLEN-1:0]  resv_addr;
    logic [`LSU_XLEN-1:0]  exp_result;
    logic [`LSU_LANES-1:0] exp_mask;
    logic                  exp_misalign;
    logic [5:0]            chk_idx;
    logic                  busy;
    int                    errors;
    int                    timeouts;

    lsu_top i_dut (
        .clk              (clk),
        .rst              (rst),
        .mem_op_i         (mem_op),
        .amo_op_i         (amo_op),
        .addr_i           (addr),
        .wdata_i          (wdata),
        .done_o           (done),
        .result_o         (result),
        .stall_o          (stall),
        .misalign_o       (misalign),
        .mem_addr_o       (mem_addr),
        .mem_addr_valid_o (mem_addr_valid),
        .mem_write_o      (mem_write),
        .mem_mask_o       (mem_mask),
        .mem_wdata_o      (mem_wdata),
        .mem_data_ready_i (mem_data_ready),
        .mem_rdata_i      (mem_rdata)
    );

    tb_lsu_mem i_mem (
        .clk          (clk),
        .rst          (rst),
        .addr_valid_i (mem_addr_valid),
        .addr_i       (mem_addr),
        .write_i      (mem_write),
        .mask_i       (mem_mask),
        .wdata_i      (mem_wdata),
        .ready_o      (mem_data_ready),
        .rdata_o      (mem_rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic count_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    a_done_reset: assert property (@(posedge clk) rst |-> !done)
        else count_error("done high during reset");
    // a pulse answers the op held in the cycle before, so no second pulse
    a_done_once: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(mem_op) != MEMOP_NONE)
        else count_error("done without an operation in flight");
    a_result: assert property (@(posedge clk) disable iff (rst)
        done && !exp_misalign |-> result == exp_result)
        else count_error($sformatf("result %h, expected %h", result, exp_result));
    a_misalign: assert property (@(posedge clk) disable iff (rst)
        done |-> misalign == exp_misalign)
        else count_error($sformatf("misalign %b, expected %b", misalign, exp_misalign));
    // the touched word holds exactly the model value after completion
    a_memory: assert property (@(posedge clk) disable iff (rst)
        done |-> i_mem.mem[chk_idx] == image[chk_idx])
        else count_error($sformatf("memory word %0d is %h, expected %h",
            chk_idx, i_mem.mem[chk_idx], image[chk_idx]));
    // the cache sees the physical address of the op
    a_addr: assert property (@(posedge clk) disable iff (rst)
        mem_addr_valid |-> mem_addr == addr)
        else count_error($sformatf("address %h, expected %h", mem_addr, addr));
    a_mask: assert property (@(posedge clk) disable iff (rst)
        mem_addr_valid && mem_write |-> mem_mask == exp_mask)
        else count_error($sformatf("mask %b, expected %b", mem_mask, exp_mask));
    a_trap_no_bus: assert property (@(posedge clk) disable iff (rst)
        busy && exp_misalign |-> !mem_addr_valid)
        else count_error("bus request for a misaligned atomic");
    a_stall_busy: assert property (@(posedge clk) disable iff (rst) busy |-> stall)
        else count_error("stall low while an operation is active");
    a_stall_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> !stall)
        else count_error("stall high with no operation");

    // new memory value by the amo rule
    function automatic logic [31:0] amo_ref(input amo_op_e kind, input logic [31:0] m,
                                            input logic [31:0] v);
        case (kind)
            AMOOP_ADD:  return m + v;
            AMOOP_XOR:  return m ^ v;
            AMOOP_AND:  return m & v;
            AMOOP_OR:   return m | v;
            AMOOP_MIN:  return ($signed(m) <= $signed(v)) ? m : v;
            AMOOP_MAX:  return ($signed(m) >= $signed(v)) ? m : v;
            AMOOP_MINU: return (m <= v) ? m : v;
            AMOOP_MAXU: return (m >= v) ? m : v;
            default:    return v;
        endcase
    endfunction

    task automatic end_run();
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // drive one op on a falling edge and update the model, then wait for done
    task automatic run_op(input mem_op_e op, input amo_op_e kind, input logic [31:0] a,
                          input logic [31:0] d);
        int          cycles;
        logic [1:0]  off;
        logic [31:0] old;
        logic        hit;
        // nothing more is issued once a wait has run out
        if (timeouts != 0) begin
            return;
        end
        chk_idx      = a[7:2];
        off          = a[1:0];
        old          = image[chk_idx];
        hit          = resv_valid && (resv_addr == a);
        exp_result   = '0;
        exp_mask     = 4'b1111;
        exp_misalign = op inside {MEMOP_LR_W, MEMOP_SC_W, MEMOP_AMO} && off != 2'b00;
        case (op)
            MEMOP_LB:  exp_result = {{24{old[8*off+7]}}, old[8*off +: 8]};
            MEMOP_LBU: exp_result = {24'b0, old[8*off +: 8]};
            MEMOP_LH:  exp_result = {{16{old[16*off[1]+15]}}, old[16*off[1] +: 16]};
            MEMOP_LHU: exp_result = {16'b0, old[16*off[1] +: 16]};
            MEMOP_LW:  exp_result = old;
            MEMOP_SB: begin
                exp_mask = 4'b0001 << off;
                image[chk_idx][8*off +: 8] = d[7:0];
                resv_valid = 1'b0;
            end
            MEMOP_SH: begin
                exp_mask = 4'b0011 << off;
                image[chk_idx][16*off[1] +: 16] = d[15:0];
                resv_valid = 1'b0;
            end
            MEMOP_SW: begin
                image[chk_idx] = d;
                resv_valid = 1'b0;
            end
            MEMOP_LR_W: begin
                exp_result = old;
                if (!exp_misalign) begin
                    resv_valid = 1'b1;
                    resv_addr  = a;
                end
            end
            MEMOP_SC_W: begin
                // 0 on success and 1 on failure
                exp_result = hit ? 32'd0 : 32'd1;
                if (hit && !exp_misalign) begin
                    image[chk_idx] = d;
                end
                // the reservation ends either way
                resv_valid = 1'b0;
            end
            MEMOP_AMO: begin
                exp_result = old;
                if (!exp_misalign) begin
                    image[chk_idx] = amo_ref(kind, old, d);
                end
            end
            default: ;
        endcase
        mem_op = op;
        amo_op = kind;
        addr   = a;
        wdata  = d;
        busy   = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < 200);
        if (!done) begin
            timeouts++;
            $display("timeout: no done for %s at address %h", op.name(), a);
        end else begin
            // one idle cycle before the next op
            mem_op = MEMOP_NONE;
            busy   = 1'b0;
            @(negedge clk);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        rst = 1'b1;
        mem_op = MEMOP_NONE;
        amo_op = AMOOP_SWAP;
        addr = '0;
        wdata = '0;
        busy = 1'b0;
        resv_valid = 1'b0;
        resv_addr = '0;
        exp_result = '0;
        exp_mask = 4'b1111;
        exp_misalign = 1'b0;
        chk_idx = '0;
        errors = 0;
        timeouts = 0;
        void'($urandom(7));
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 64; i++) begin
            image[i] = i_mem.mem[i];
        end
        // store then load back with both signs of the top data bit
        for (int n = 0; n < 12; n++) begin
            a = $urandom & 32'hfc;
            d = $urandom;
            d[7] = n[1];
            d[15] = n[0];
            if (n % 3 == 0) begin
                a[1:0] = 2'($urandom % 4);
                run_op(MEMOP_SB, AMOOP_SWAP, a, d);
                run_op(MEMOP_LB, AMOOP_SWAP, a, 32'd0);
                run_op(MEMOP_LBU, AMOOP_SWAP, a, 32'd0);
            end else if (n % 3 == 1) begin
                a[1] = 1'($urandom % 2);
                run_op(MEMOP_SH, AMOOP_SWAP, a, d);
                run_op(MEMOP_LH, AMOOP_SWAP, a, 32'd0);
                run_op(MEMOP_LHU, AMOOP_SWAP, a, 32'd0);
            end else begin
                run_op(MEMOP_SW, AMOOP_SWAP, a, d);
                run_op(MEMOP_LW, AMOOP_SWAP, a, 32'd0);
            end
        end
        // every amo kind with mixed signs and then with equal signs
        for (int k = 0; k < 18; k++) begin
            a = $urandom & 32'hfc;
            d = $urandom;
            d[31] = image[a[7:2]][31] ^ (k < 9);
            run_op(MEMOP_AMO, amo_op_e'(k % 9), a, d);
        end
        // lr and sc to one word, then sc with no reservation, to another word
        // and after a plain store
        a = $urandom & 32'h7c;
        run_op(MEMOP_LR_W, AMOOP_SWAP, a, 32'd0);
        run_op(MEMOP_SC_W, AMOOP_SWAP, a, $urandom);
        run_op(MEMOP_SC_W, AMOOP_SWAP, a, $urandom);
        run_op(MEMOP_LR_W, AMOOP_SWAP, a, 32'd0);
        run_op(MEMOP_SC_W, AMOOP_SWAP, a + 32'h80, $urandom);
        run_op(MEMOP_LR_W, AMOOP_SWAP, a, 32'd0);
        run_op(MEMOP_SW, AMOOP_SWAP, a + 32'h84, $urandom);
        run_op(MEMOP_SC_W, AMOOP_SWAP, a, $urandom);
        // misaligned atomics trap without a bus access
        run_op(MEMOP_AMO, AMOOP_ADD, a | 32'd1, $urandom);
        run_op(MEMOP_LR_W, AMOOP_SWAP, a | 32'd2, 32'd0);
        run_op(MEMOP_SC_W, AMOOP_SWAP, a | 32'd3, $urandom);
        end_run();
    end

endmodule

//--- tests/tb_lsu_mem.sv
`timescale 1ns/10ps
`include "lsu_params.svh"

module tb_lsu_mem (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  addr_valid_i,
    input  logic [`LSU_XLEN-1:0]  addr_i,
    input  logic                  write_i,
    input  logic [`LSU_LANES-1:0] mask_i,
    input  logic [`LSU_XLEN-1:0]  wdata_i,
    output logic                  ready_o,
    output logic [`LSU_XLEN-1:0]  rdata_o
);

    localparam int DEPTH = 64;

    logic [`LSU_XLEN-1:0] mem [DEPTH];
    logic [1:0]           wait_q;
    logic [5:0]           idx;

    // higher address bits wrap around the word index
    assign idx = addr_i[7:2];

    // ready once the wait has run out, possibly in the request cycle itself
    assign ready_o = addr_valid_i && (wait_q == 2'd0);
    assign rdata_o = mem[idx];

    // fill pattern differs for every word address
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= (i * 32'h9e37_79b9) ^ (i << 20);
        end
    end

    // random delay for the request that follows
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_q <= 2'd0;
        end else if (ready_o) begin
            wait_q <= 2'($urandom % 4);
        end else if (addr_valid_i) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    // byte-masked write on the ready strobe
    always @(posedge clk) begin
        if (ready_o && write_i) begin
            for (int l = 0; l < `LSU_LANES; l++) begin
                // lanes outside the mask keep their value
                if (mask_i[l]) begin
                    mem[idx][8*l +: 8] <= wdata_i[8*l +: 8];
                end
            end
        end
    end

endmodule
